/* Bender.yml */
package:
  name: retire_stage

sources:
  - files:
      - hw/retire_pkg.sv
      - hw/retire_decode.sv
      - hw/retire_waw_resolve.sv
      - hw/retire_writeback.sv
      - hw/retire_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_retire.sv

/* compile.f */
+incdir+testbench
hw/retire_pkg.sv
hw/retire_decode.sv
hw/retire_waw_resolve.sv
hw/retire_writeback.sv
hw/retire_top.sv
testbench/tb_retire.sv

/* hw/retire_decode.sv */
/*
 * Retire decode
 * Splits each ROB slot into its fields, squashes slots younger than a trap
 * and builds the byte strobe and saturation flag from BODY_ACTIVE bytes
 */

`timescale 1ns/1ns

module retire_decode import retire_pkg::*; #(
    parameter int NUM_RT_UOP = NUM_RT_UOP_DEF
) (
    input  logic     [NUM_RT_UOP-1:0] rob_valid_i,
    input  rob2rt_t  [NUM_RT_UOP-1:0] rob_data_i,
    output uop_dec_t [NUM_RT_UOP-1:0] dec_o
);

    logic [NUM_RT_UOP-1:0] trap_before;    // Some older slot trapped
    logic [NUM_RT_UOP-1:0] survive;

    ////////////////////////////////////////////////////////////////////////////
    // Trap squash chain, oldest to youngest
    ////////////////////////////////////////////////////////////////////////////
    for (genvar i = 0; i < NUM_RT_UOP; i++) begin : g_chain
        if (i == 0) begin : g_oldest
            assign trap_before[i] = 1'b0;    // Nothing older than slot 0
        end else begin : g_younger
            assign trap_before[i] = trap_before[i-1] |
                                    (rob_valid_i[i-1] & rob_data_i[i-1].trap_flag);
        end

        assign survive[i] = rob_valid_i[i] & rob_data_i[i].w_valid & ~trap_before[i];
    end

    ////////////////////////////////////////////////////////////////////////////
    // Per-slot decode
    ////////////////////////////////////////////////////////////////////////////
    for (genvar i = 0; i < NUM_RT_UOP; i++) begin : g_slot
        byte_strobe_t raw_strobe;
        uop_dec_t     slot_dec;

        // Byte enable from element type
        always_comb begin
            raw_strobe = '0;
            for (int b = 0; b < VLENB; b++) begin
                raw_strobe[b] = (rob_data_i[i].vd_type[b] == BODY_ACTIVE);
            end
        end

        always_comb begin
            slot_dec.vrf_hit = survive[i] & ~rob_data_i[i].w_type;
            slot_dec.xrf_hit = survive[i] &  rob_data_i[i].w_type;
            slot_dec.index   = rob_data_i[i].w_index;
            slot_dec.data    = rob_data_i[i].w_data;
            slot_dec.strobe  = raw_strobe;
            // Saturation only counts on bytes that are really written
            slot_dec.sat     = |(raw_strobe & rob_data_i[i].vxsaturate);
        end

        assign dec_o[i] = slot_dec;
    end

endmodule

/* hw/retire_pkg.sv */
/*
 * Retire stage shared types
 * Widths, vector typedefs, byte element type and the packed structs
 * exchanged between the ROB, the retire stages and the register files
 */

package retire_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////
    localparam int NUM_RT_UOP_DEF = 4;          // Default retire slot count
    localparam int VLEN           = 128;
    localparam int VLENB          = VLEN / 8;   // Bytes per vector register
    localparam int XLEN           = 32;
    localparam int REG_IDX_W      = 5;

    typedef logic [VLEN-1:0]      vreg_data_t;
    typedef logic [XLEN-1:0]      xreg_data_t;
    typedef logic [VLENB-1:0]     byte_strobe_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // Element type of one destination byte
    typedef enum logic [1:0] {
        BODY_INACTIVE = 2'd0,
        TAIL          = 2'd1,
        PROLOGUE      = 2'd2,
        BODY_ACTIVE   = 2'd3     // Only these bytes get written
    } byte_type_e;

    ////////////////////////////////////////////////////////////////////////////
    // Structs
    ////////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [6:0] vstart;
        logic [7:0] vl;
        logic [2:0] vsew;
        logic [2:0] vlmul;
    } vcsr_state_t;

    // One retired uop as handed over by the ROB
    typedef struct packed {
        logic                         w_type;      // 0 VRF, 1 XRF
        logic                         w_valid;
        reg_idx_t                     w_index;
        vreg_data_t                   w_data;
        byte_type_e [VLENB-1:0]       vd_type;
        byte_strobe_t                 vxsaturate;
        logic                         trap_flag;
        vcsr_state_t                  vector_csr;
    } rob2rt_t;

    // Decoded slot, after trap squash
    typedef struct packed {
        logic         vrf_hit;
        logic         xrf_hit;
        reg_idx_t     index;
        vreg_data_t   data;
        byte_strobe_t strobe;      // Raw, before WAW masking
        logic         sat;
    } uop_dec_t;

    typedef struct packed {
        reg_idx_t     rt_index;
        vreg_data_t   rt_data;
        byte_strobe_t rt_strobe;
    } rt2vrf_t;

    typedef struct packed {
        reg_idx_t   rt_index;
        xreg_data_t rt_data;
    } rt2xrf_t;

endpackage

/* hw/retire_top.sv */
/*
 * Retire stage top level
 * Decode, WAW resolution and registered writeback to VRF, XRF and CSRs
 */

`timescale 1ns/1ns

module retire_top import retire_pkg::*; #(
    parameter int NUM_RT_UOP = NUM_RT_UOP_DEF
) (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic     [NUM_RT_UOP-1:0]    rob_valid_i,
    input  rob2rt_t  [NUM_RT_UOP-1:0]    rob_data_i,
    output logic     [NUM_RT_UOP-1:0]    vrf_valid_o,
    output rt2vrf_t  [NUM_RT_UOP-1:0]    vrf_data_o,
    output logic     [NUM_RT_UOP-1:0]    xrf_valid_o,
    output rt2xrf_t  [NUM_RT_UOP-1:0]    xrf_data_o,
    output logic                         vcsr_valid_o,
    output vcsr_state_t                  vcsr_data_o,
    output logic                         vxsat_valid_o,
    output logic                         vxsat_data_o
);

    uop_dec_t     [NUM_RT_UOP-1:0] dec;
    byte_strobe_t [NUM_RT_UOP-1:0] waw_strobe;   // Strobes after WAW masking

    retire_decode #(.NUM_RT_UOP(NUM_RT_UOP)) u_decode (
        .rob_valid_i (rob_valid_i),
        .rob_data_i  (rob_data_i),
        .dec_o       (dec)
    );

    retire_waw_resolve #(.NUM_RT_UOP(NUM_RT_UOP)) u_waw (
        .dec_i    (dec),
        .strobe_o (waw_strobe)
    );

    // Single register stage, all outputs
    retire_writeback #(.NUM_RT_UOP(NUM_RT_UOP)) u_writeback (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .rob_data_i    (rob_data_i),
        .dec_i         (dec),
        .strobe_i      (waw_strobe),
        .vrf_valid_o   (vrf_valid_o),
        .vrf_data_o    (vrf_data_o),
        .xrf_valid_o   (xrf_valid_o),
        .xrf_data_o    (xrf_data_o),
        .vcsr_valid_o  (vcsr_valid_o),
        .vcsr_data_o   (vcsr_data_o),
        .vxsat_valid_o (vxsat_valid_o),
        .vxsat_data_o  (vxsat_data_o)
    );

endmodule

/* hw/retire_waw_resolve.sv */
/*
 * Write-after-write resolution
 * Clears every strobe byte of a VRF write that a younger surviving write
 * to the same register also covers, so the youngest writer wins
 */

`timescale 1ns/1ns

module retire_waw_resolve import retire_pkg::*; #(
    parameter int NUM_RT_UOP = NUM_RT_UOP_DEF
) (
    input  uop_dec_t     [NUM_RT_UOP-1:0] dec_i,
    output byte_strobe_t [NUM_RT_UOP-1:0] strobe_o
);

    ////////////////////////////////////////////////////////////////////////////
    // Younger coverage per slot
    ////////////////////////////////////////////////////////////////////////////
    for (genvar i = 0; i < NUM_RT_UOP; i++) begin : g_slot
        byte_strobe_t covered;    // Bytes owned by younger same-index writes

        // Loop is empty for the youngest slot, so its strobe passes through
        always_comb begin
            covered = '0;
            for (int j = i + 1; j < NUM_RT_UOP; j++) begin
                // Squashed slots have no vrf_hit and never mask older ones
                if (dec_i[j].vrf_hit && (dec_i[j].index == dec_i[i].index)) begin
                    covered = covered | dec_i[j].strobe;
                end
            end
        end

        assign strobe_o[i] = dec_i[i].strobe & ~covered;
    end

endmodule

/* hw/retire_writeback.sv */
/*
 * Retire writeback
 * Packs VRF, XRF, CSR and vxsat writes and registers them for one cycle
 */

`timescale 1ns/1ns

module retire_writeback import retire_pkg::*; #(
    parameter int NUM_RT_UOP = NUM_RT_UOP_DEF
) (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  rob2rt_t      [NUM_RT_UOP-1:0]    rob_data_i,
    input  uop_dec_t     [NUM_RT_UOP-1:0]    dec_i,
    input  byte_strobe_t [NUM_RT_UOP-1:0]    strobe_i,
    output logic         [NUM_RT_UOP-1:0]    vrf_valid_o,
    output rt2vrf_t      [NUM_RT_UOP-1:0]    vrf_data_o,
    output logic         [NUM_RT_UOP-1:0]    xrf_valid_o,
    output rt2xrf_t      [NUM_RT_UOP-1:0]    xrf_data_o,
    output logic                             vcsr_valid_o,
    output vcsr_state_t                      vcsr_data_o,
    output logic                             vxsat_valid_o,
    output logic                             vxsat_data_o
);

    logic    [NUM_RT_UOP-1:0] vrf_valid_d;
    rt2vrf_t [NUM_RT_UOP-1:0] vrf_data_d;
    logic    [NUM_RT_UOP-1:0] xrf_valid_d;
    rt2xrf_t [NUM_RT_UOP-1:0] xrf_data_d;
    logic                     vcsr_valid_d;
    logic                     vxsat_valid_d;
    logic                     vxsat_data_d;

    ////////////////////////////////////////////////////////////////////////////
    // Next-state packing
    ////////////////////////////////////////////////////////////////////////////
    for (genvar i = 0; i < NUM_RT_UOP; i++) begin : g_pack
        assign vrf_valid_d[i] = dec_i[i].vrf_hit;
        assign vrf_data_d[i]  = '{rt_index:  dec_i[i].index,
                                  rt_data:   dec_i[i].data,
                                  rt_strobe: strobe_i[i]};

        assign xrf_valid_d[i] = dec_i[i].xrf_hit;
        assign xrf_data_d[i]  = '{rt_index: dec_i[i].index,
                                  rt_data:  dec_i[i].data[XLEN-1:0]};   // Low word only
    end

    // Slot 0 always survives the squash, so a hit there means valid and w_valid
    assign vcsr_valid_d = (dec_i[0].vrf_hit | dec_i[0].xrf_hit) & rob_data_i[0].trap_flag;

    always_comb begin
        vxsat_valid_d = 1'b0;
        vxsat_data_d  = 1'b0;
        for (int i = 0; i < NUM_RT_UOP; i++) begin
            vxsat_valid_d = vxsat_valid_d | ((dec_i[i].vrf_hit | dec_i[i].xrf_hit) & dec_i[i].sat);
            vxsat_data_d  = vxsat_data_d | dec_i[i].sat;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            vrf_valid_o   <= '0;
            vrf_data_o    <= '0;
            xrf_valid_o   <= '0;
            xrf_data_o    <= '0;
            vcsr_valid_o  <= 1'b0;
            vcsr_data_o   <= '0;
            vxsat_valid_o <= 1'b0;
            vxsat_data_o  <= 1'b0;
        end else begin
            vrf_valid_o   <= vrf_valid_d;
            vrf_data_o    <= vrf_data_d;
            xrf_valid_o   <= xrf_valid_d;
            xrf_data_o    <= xrf_data_d;
            vcsr_valid_o  <= vcsr_valid_d;
            vcsr_data_o   <= rob_data_i[0].vector_csr;
            vxsat_valid_o <= vxsat_valid_d;
            vxsat_data_o  <= vxsat_data_d;
        end
    end

    // Registered VRF ports never fight over a byte, and a slot targets one file
    for (genvar i = 0; i < NUM_RT_UOP; i++) begin : g_chk
        for (genvar j = 0; j < i; j++) begin : g_pair
            a_vrf_no_overlap: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                !(vrf_valid_o[i] && vrf_valid_o[j] &&
                  (vrf_data_o[i].rt_index == vrf_data_o[j].rt_index) &&
                  |(vrf_data_o[i].rt_strobe & vrf_data_o[j].rt_strobe)))
                else $error("VRF slots %0d and %0d overlap on vrf[%0d]",
                            i, j, vrf_data_o[i].rt_index);
        end

        a_one_file: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            !(vrf_valid_o[i] && xrf_valid_o[i]))
            else $error("Slot %0d writes both VRF and XRF", i);
    end

endmodule

/* testbench/retire_model.svh */
/*
 * Retire stage reference model
 * Expected registered outputs for one set of ROB slots
 */

`ifndef RETIRE_MODEL_SVH
`define RETIRE_MODEL_SVH

typedef struct packed {
    logic    [NUM_RT-1:0] vrf_valid;
    rt2vrf_t [NUM_RT-1:0] vrf_data;
    logic    [NUM_RT-1:0] xrf_valid;
    rt2xrf_t [NUM_RT-1:0] xrf_data;
    logic                 vcsr_valid;
    vcsr_state_t          vcsr_data;
    logic                 vxsat_valid;
    logic                 vxsat_data;
} retire_expect_t;

function automatic retire_expect_t compute_expected(
    input logic    [NUM_RT-1:0] valid,
    input rob2rt_t [NUM_RT-1:0] rob
);
    retire_expect_t    e;
    byte_strobe_t      active [NUM_RT];
    logic [NUM_RT-1:0] alive;
    logic              trapped;

    e       = '0;
    trapped = 1'b0;
    for (int s = 0; s < NUM_RT; s++) begin
        alive[s] = valid[s] && rob[s].w_valid && !trapped;
        trapped  = trapped || (valid[s] && rob[s].trap_flag);   // Kills every younger slot
        for (int b = 0; b < VLENB; b++) begin
            active[s][b] = (rob[s].vd_type[b] == BODY_ACTIVE);
        end
    end

    for (int s = 0; s < NUM_RT; s++) begin
        if (alive[s] && !rob[s].w_type) begin
            e.vrf_valid[s] = 1'b1;
            e.vrf_data[s]  = '{rt_index: rob[s].w_index, rt_data: rob[s].w_data,
                               rt_strobe: active[s]};
            // Younger live writer of the same register owns the byte
            for (int y = s + 1; y < NUM_RT; y++) begin
                if (alive[y] && !rob[y].w_type && (rob[y].w_index == rob[s].w_index)) begin
                    e.vrf_data[s].rt_strobe = e.vrf_data[s].rt_strobe & ~active[y];
                end
            end
        end
        if (alive[s] && rob[s].w_type) begin
            e.xrf_valid[s] = 1'b1;
            e.xrf_data[s]  = '{rt_index: rob[s].w_index, rt_data: rob[s].w_data[XLEN-1:0]};
        end
        if (alive[s] && |(active[s] & rob[s].vxsaturate)) begin
            e.vxsat_valid = 1'b1;
            e.vxsat_data  = 1'b1;
        end
    end

    e.vcsr_valid = valid[0] && rob[0].w_valid && rob[0].trap_flag;
    e.vcsr_data  = rob[0].vector_csr;
    return e;
endfunction

`endif

/* testbench/tb_retire.sv */
/*
 * Retire stage testbench
 * Random ROB slots from a fixed seed, checked one cycle later against a model
 */

`timescale 1ns/1ns

module tb_retire
    import retire_pkg::*;
();

    localparam int          NUM_RT        = NUM_RT_UOP_DEF;
    localparam int          NUM_CYCLES    = 2000;
    localparam int          RESET_TIMEOUT = 20;     // Cycles
    localparam int unsigned SEED          = 32'h1447_760a;

    logic                     clk;
    logic                     rst_n;
    logic        [NUM_RT-1:0] rob_valid;
    rob2rt_t     [NUM_RT-1:0] rob_data;
    logic        [NUM_RT-1:0] vrf_valid;
    rt2vrf_t     [NUM_RT-1:0] vrf_data;
    logic        [NUM_RT-1:0] xrf_valid;
    rt2xrf_t     [NUM_RT-1:0] xrf_data;
    logic                     vcsr_valid;
    vcsr_state_t              vcsr_data;
    logic                     vxsat_valid;
    logic                     vxsat_data;

    `include "retire_model.svh"

    retire_expect_t exp_q[$];      // One entry per driven input set
    int             err_cnt     = 0;
    int             check_cnt   = 0;
    int             timeout_cnt = 0;

    retire_top #(.NUM_RT_UOP(NUM_RT)) u_dut (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .rob_valid_i   (rob_valid),
        .rob_data_i    (rob_data),
        .vrf_valid_o   (vrf_valid),
        .vrf_data_o    (vrf_data),
        .xrf_valid_o   (xrf_valid),
        .xrf_data_o    (xrf_data),
        .vcsr_valid_o  (vcsr_valid),
        .vcsr_data_o   (vcsr_data),
        .vxsat_valid_o (vxsat_valid),
        .vxsat_data_o  (vxsat_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////
    task automatic report_mismatch(input string msg);
        err_cnt++;
        $display("[FAIL] %0t ns: %s", $time, msg);
    endtask

    task automatic check_outputs(input retire_expect_t e);
        for (int s = 0; s < NUM_RT; s++) begin
            check_cnt++;
            assert ((vrf_valid[s] == e.vrf_valid[s]) &&
                    (!e.vrf_valid[s] || (vrf_data[s] == e.vrf_data[s]))) else
                report_mismatch($sformatf(
                    "slot %0d VRF v%0b vrf[%0d] strb %h, exp v%0b vrf[%0d] strb %h",
                    s, vrf_valid[s], vrf_data[s].rt_index, vrf_data[s].rt_strobe,
                    e.vrf_valid[s], e.vrf_data[s].rt_index, e.vrf_data[s].rt_strobe));
            assert ((xrf_valid[s] == e.xrf_valid[s]) &&
                    (!e.xrf_valid[s] || (xrf_data[s] == e.xrf_data[s]))) else
                report_mismatch($sformatf("slot %0d XRF v%0b x%0d=%h, exp v%0b x%0d=%h",
                    s, xrf_valid[s], xrf_data[s].rt_index, xrf_data[s].rt_data,
                    e.xrf_valid[s], e.xrf_data[s].rt_index, e.xrf_data[s].rt_data));
            for (int o = 0; o < s; o++) begin
                assert (!(vrf_valid[s] && vrf_valid[o] &&
                          (vrf_data[s].rt_index == vrf_data[o].rt_index) &&
                          |(vrf_data[s].rt_strobe & vrf_data[o].rt_strobe))) else
                    report_mismatch($sformatf("VRF slots %0d and %0d overlap", o, s));
            end
        end
        check_cnt++;
        assert ((vcsr_valid == e.vcsr_valid) && (!e.vcsr_valid || (vcsr_data == e.vcsr_data)))
            else report_mismatch($sformatf("CSR v%0b data %h, exp v%0b data %h",
                vcsr_valid, vcsr_data, e.vcsr_valid, e.vcsr_data));
        assert ((vxsat_valid == e.vxsat_valid) && (!e.vxsat_valid || vxsat_data))
            else report_mismatch($sformatf("vxsat v%0b d%0b, exp v%0b d1",
                vxsat_valid, vxsat_data, e.vxsat_valid));
    endtask

    task automatic build_random_slots(output logic [NUM_RT-1:0] v,
                                      output rob2rt_t [NUM_RT-1:0] d);
        int r;
        for (int s = 0; s < NUM_RT; s++) begin
            v[s]           = ($urandom_range(0, 3) != 0);
            d[s].w_type    = $urandom_range(0, 1);
            d[s].w_valid   = ($urandom_range(0, 7) != 0);
            d[s].w_index   = $urandom_range(0, 3);      // Narrow range forces WAW hits
            d[s].w_data    = {$urandom, $urandom, $urandom, $urandom};
            for (int b = 0; b < VLENB; b++) begin
                r = $urandom_range(0, 5);
                d[s].vd_type[b] = (r > 3) ? BODY_ACTIVE : byte_type_e'(r);
            end
            d[s].vxsaturate = ($urandom_range(0, 3) == 0) ? byte_strobe_t'($urandom) : '0;
            d[s].trap_flag  = ($urandom_range(0, 7) == 0);
            d[s].vector_csr = vcsr_state_t'($urandom);
        end
    endtask

    // Valids must stay low in reset and in the cycle after release
    // Random slots keep coming in, so a missing reset would show up here
    task automatic wait_reset_release(output logic released);
        int                   cycles;
        logic    [NUM_RT-1:0] v;
        rob2rt_t [NUM_RT-1:0] d;
        released = 1'b0;
        cycles   = 0;
        while (!released && (cycles < RESET_TIMEOUT)) begin
            @(posedge clk);
            build_random_slots(v, d);
            rob_valid <= v;
            rob_data  <= d;
            @(negedge clk);
            check_cnt++;
            assert ((vrf_valid == '0) && (xrf_valid == '0) && !vcsr_valid && !vxsat_valid)
                else report_mismatch("output valid set around reset");
            released = rst_n;
            cycles++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        logic                 released;
        logic    [NUM_RT-1:0] v;
        rob2rt_t [NUM_RT-1:0] d;

        void'($urandom(SEED));
        rob_valid = '0;
        rob_data  = '0;
        wait_reset_release(released);
        if (released) begin
            // Set still held at the first edge after release
            exp_q.push_back(compute_expected(rob_valid, rob_data));
            for (int c = 0; c < NUM_CYCLES; c++) begin
                @(posedge clk);
                build_random_slots(v, d);
                rob_valid <= v;
                rob_data  <= d;
                exp_q.push_back(compute_expected(v, d));
                @(negedge clk);
                check_outputs(exp_q.pop_front());
            end
            @(posedge clk);
            rob_valid <= '0;
            rob_data  <= '0;
            @(negedge clk);
            check_outputs(exp_q.pop_front());     // Last random set
        end else begin
            timeout_cnt++;
            $display("Timeout: reset still asserted after %0d cycles", RESET_TIMEOUT);
        end
        $display("Checks: %0d, errors: %0d, timeouts: %0d", check_cnt, err_cnt, timeout_cnt);
        if ((err_cnt == 0) && (timeout_cnt == 0)) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
